// File: common/pkt_proc_pkg.sv
`default_nettype none

package pkt_proc_pkg;

    // packet byte length or byte offset within a packet
    typedef logic [15:0] byte_len_t;

    // switch port number
    typedef logic [3:0] port_t;

    // all ones means the packet is never cut
    localparam byte_len_t BYTE_LEN_MAX = '1;

    // widest keep vector the helpers handle, covers DATA_BYTES up to 64
    localparam int KEEP_MAX = 64;

    // ------------------------------------------------------------
    // byte length helpers
    // ------------------------------------------------------------

    // number of valid bytes in a (zero extended) keep vector
    function automatic byte_len_t keep_bytes(input logic [KEEP_MAX-1:0] keep);
        byte_len_t count;
        count = '0;
        for (int i = 0; i < KEEP_MAX; i++) begin
            count = count + byte_len_t'(keep[i]);
        end
        return count;
    endfunction

    // contiguous keep mask with the lowest n bytes set
    function automatic logic [KEEP_MAX-1:0] keep_mask(input byte_len_t n);
        logic [KEEP_MAX-1:0] mask;
        for (int i = 0; i < KEEP_MAX; i++) begin
            mask[i] = (byte_len_t'(i) < n);
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: hdl/meta_resolve.sv
`default_nettype none

module meta_resolve
    import pkt_proc_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [DATA_BYTES*8-1:0] in_data,
    input  logic [DATA_BYTES-1:0]   in_keep,
    input  logic                    in_last,
    input  port_t                   in_ingress_port,
    input  port_t                   in_egress_port,
    input  logic                    in_trunc_enable,
    input  byte_len_t               in_trunc_length,

    input  logic                    cfg_trunc_override,
    input  logic                    cfg_trunc_enable,
    input  byte_len_t               cfg_trunc_length,

    output logic                    rs_valid,
    input  logic                    rs_ready,
    output logic [DATA_BYTES*8-1:0] rs_data,
    output logic [DATA_BYTES-1:0]   rs_keep,
    output logic                    rs_last,
    output port_t                   rs_ingress_port,
    output port_t                   rs_egress_port,
    output byte_len_t               rs_trunc_length
);

    logic      cfg_override_q;
    logic      cfg_enable_q;
    byte_len_t cfg_length_q;

    logic      in_sop;
    logic      in_xfer;

    // copy of the first-beat metadata for the rest of the packet
    port_t     ingress_q;
    port_t     egress_q;
    logic      trunc_enable_q;
    byte_len_t trunc_length_q;

    port_t     cur_ingress;
    port_t     cur_egress;
    logic      cur_trunc_enable;
    byte_len_t cur_trunc_length;
    byte_len_t resolved_length;

    assign in_ready = !rs_valid || rs_ready;
    assign in_xfer  = in_valid && in_ready;

    // ------------------------------------------------------------
    // configuration and packet start tracking
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_override_q <= 1'b0;
            cfg_enable_q   <= 1'b0;
            cfg_length_q   <= BYTE_LEN_MAX;
            in_sop         <= 1'b1;
        end else begin
            cfg_override_q <= cfg_trunc_override;
            cfg_enable_q   <= cfg_trunc_enable;
            cfg_length_q   <= cfg_trunc_length;
            if (in_xfer) begin
                in_sop <= in_last;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer && in_sop) begin
            ingress_q      <= in_ingress_port;
            egress_q       <= in_egress_port;
            trunc_enable_q <= in_trunc_enable;
            trunc_length_q <= in_trunc_length;
        end
    end

    // live metadata on the first beat, latched copy afterwards
    assign cur_ingress      = in_sop ? in_ingress_port : ingress_q;
    assign cur_egress       = in_sop ? in_egress_port  : egress_q;
    assign cur_trunc_enable = in_sop ? in_trunc_enable : trunc_enable_q;
    assign cur_trunc_length = in_sop ? in_trunc_length : trunc_length_q;

    // override replaces the per-packet truncation request
    always_comb begin
        if (cfg_override_q) begin
            resolved_length = cfg_enable_q ? cfg_length_q : BYTE_LEN_MAX;
        end else begin
            resolved_length = cur_trunc_enable ? cur_trunc_length : BYTE_LEN_MAX;
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_valid <= 1'b0;
        end else if (in_ready) begin
            rs_valid <= in_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer) begin
            rs_data         <= in_data;
            rs_keep         <= in_keep;
            rs_last         <= in_last;
            rs_ingress_port <= cur_ingress;
            rs_egress_port  <= cur_egress;
            rs_trunc_length <= resolved_length;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pkt_proc_top.sv
`default_nettype none

module pkt_proc_top
    import pkt_proc_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [DATA_BYTES*8-1:0] in_data,
    input  logic [DATA_BYTES-1:0]   in_keep,
    input  logic                    in_last,
    input  port_t                   in_ingress_port,
    input  port_t                   in_egress_port,
    input  logic                    in_trunc_enable,
    input  byte_len_t               in_trunc_length,

    input  logic                    cfg_trunc_override,
    input  logic                    cfg_trunc_enable,
    input  byte_len_t               cfg_trunc_length,
    input  logic                    cfg_drop_loop,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_BYTES*8-1:0] out_data,
    output logic [DATA_BYTES-1:0]   out_keep,
    output logic                    out_last,
    output port_t                   out_ingress_port,
    output port_t                   out_egress_port,

    output logic [31:0]             drop_count
);

    // ------------------------------------------------------------
    // resolved stream, meta_resolve to pkt_drop
    // ------------------------------------------------------------
    logic                    rs_valid;
    logic                    rs_ready;
    logic [DATA_BYTES*8-1:0] rs_data;
    logic [DATA_BYTES-1:0]   rs_keep;
    logic                    rs_last;
    port_t                   rs_ingress_port;
    port_t                   rs_egress_port;
    byte_len_t               rs_trunc_length;

    // ------------------------------------------------------------
    // filtered stream, pkt_drop to pkt_trunc
    // ------------------------------------------------------------
    logic                    dp_valid;
    logic                    dp_ready;
    logic [DATA_BYTES*8-1:0] dp_data;
    logic [DATA_BYTES-1:0]   dp_keep;
    logic                    dp_last;
    port_t                   dp_ingress_port;
    port_t                   dp_egress_port;
    byte_len_t               dp_trunc_length;

    meta_resolve #(
        .DATA_BYTES (DATA_BYTES)
    ) i_meta_resolve (
        .core_clk           (core_clk),
        .rst_n              (rst_n),
        .in_valid           (in_valid),
        .in_ready           (in_ready),
        .in_data            (in_data),
        .in_keep            (in_keep),
        .in_last            (in_last),
        .in_ingress_port    (in_ingress_port),
        .in_egress_port     (in_egress_port),
        .in_trunc_enable    (in_trunc_enable),
        .in_trunc_length    (in_trunc_length),
        .cfg_trunc_override (cfg_trunc_override),
        .cfg_trunc_enable   (cfg_trunc_enable),
        .cfg_trunc_length   (cfg_trunc_length),
        .rs_valid           (rs_valid),
        .rs_ready           (rs_ready),
        .rs_data            (rs_data),
        .rs_keep            (rs_keep),
        .rs_last            (rs_last),
        .rs_ingress_port    (rs_ingress_port),
        .rs_egress_port     (rs_egress_port),
        .rs_trunc_length    (rs_trunc_length)
    );

    pkt_drop #(
        .DATA_BYTES (DATA_BYTES)
    ) i_pkt_drop (
        .core_clk        (core_clk),
        .rst_n           (rst_n),
        .cfg_drop_loop   (cfg_drop_loop),
        .rs_valid        (rs_valid),
        .rs_ready        (rs_ready),
        .rs_data         (rs_data),
        .rs_keep         (rs_keep),
        .rs_last         (rs_last),
        .rs_ingress_port (rs_ingress_port),
        .rs_egress_port  (rs_egress_port),
        .rs_trunc_length (rs_trunc_length),
        .dp_valid        (dp_valid),
        .dp_ready        (dp_ready),
        .dp_data         (dp_data),
        .dp_keep         (dp_keep),
        .dp_last         (dp_last),
        .dp_ingress_port (dp_ingress_port),
        .dp_egress_port  (dp_egress_port),
        .dp_trunc_length (dp_trunc_length),
        .drop_count      (drop_count)
    );

    pkt_trunc #(
        .DATA_BYTES (DATA_BYTES)
    ) i_pkt_trunc (
        .core_clk         (core_clk),
        .rst_n            (rst_n),
        .dp_valid         (dp_valid),
        .dp_ready         (dp_ready),
        .dp_data          (dp_data),
        .dp_keep          (dp_keep),
        .dp_last          (dp_last),
        .dp_ingress_port  (dp_ingress_port),
        .dp_egress_port   (dp_egress_port),
        .dp_trunc_length  (dp_trunc_length),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_ingress_port (out_ingress_port),
        .out_egress_port  (out_egress_port)
    );

endmodule

`default_nettype wire

// File: pkt_drop/pkt_drop.sv
`default_nettype none

module pkt_drop
    import pkt_proc_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    input  logic                    cfg_drop_loop,

    input  logic                    rs_valid,
    output logic                    rs_ready,
    input  logic [DATA_BYTES*8-1:0] rs_data,
    input  logic [DATA_BYTES-1:0]   rs_keep,
    input  logic                    rs_last,
    input  port_t                   rs_ingress_port,
    input  port_t                   rs_egress_port,
    input  byte_len_t               rs_trunc_length,

    output logic                    dp_valid,
    input  logic                    dp_ready,
    output logic [DATA_BYTES*8-1:0] dp_data,
    output logic [DATA_BYTES-1:0]   dp_keep,
    output logic                    dp_last,
    output port_t                   dp_ingress_port,
    output port_t                   dp_egress_port,
    output byte_len_t               dp_trunc_length,

    output logic [31:0]             drop_count
);

    logic cfg_drop_loop_q;

    logic rs_sop;
    logic rs_xfer;

    logic zero_length;
    logic loop_detect;
    logic drop_decide;
    logic drop_q;
    logic drop_beat;

    assign rs_ready = !dp_valid || dp_ready;
    assign rs_xfer  = rs_valid && rs_ready;

    // ------------------------------------------------------------
    // drop decision, taken on the first beat only
    // ------------------------------------------------------------
    assign zero_length = rs_last && (rs_keep == '0);
    assign loop_detect = cfg_drop_loop_q && (rs_egress_port == rs_ingress_port);
    assign drop_decide = zero_length || loop_detect;

    // later beats follow whatever the first beat decided
    assign drop_beat = rs_sop ? drop_decide : drop_q;

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_drop_loop_q <= 1'b0;
            rs_sop          <= 1'b1;
            drop_q          <= 1'b0;
        end else begin
            cfg_drop_loop_q <= cfg_drop_loop;
            if (rs_xfer) begin
                rs_sop <= rs_last;
                if (rs_sop) begin
                    drop_q <= drop_decide;
                end
            end
        end
    end

    // one count per dropped packet
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (rs_xfer && rs_sop && drop_decide) begin
            drop_count <= drop_count + 32'd1;
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
        end else if (rs_ready) begin
            dp_valid <= rs_valid && !drop_beat;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rs_xfer && !drop_beat) begin
            dp_data         <= rs_data;
            dp_keep         <= rs_keep;
            dp_last         <= rs_last;
            dp_ingress_port <= rs_ingress_port;
            dp_egress_port  <= rs_egress_port;
            dp_trunc_length <= rs_trunc_length;
        end
    end

endmodule

`default_nettype wire

// File: pkt_trunc/pkt_trunc.sv
`default_nettype none

module pkt_trunc
    import pkt_proc_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    rst_n,

    input  logic                    dp_valid,
    output logic                    dp_ready,
    input  logic [DATA_BYTES*8-1:0] dp_data,
    input  logic [DATA_BYTES-1:0]   dp_keep,
    input  logic                    dp_last,
    input  port_t                   dp_ingress_port,
    input  port_t                   dp_egress_port,
    input  byte_len_t               dp_trunc_length,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_BYTES*8-1:0] out_data,
    output logic [DATA_BYTES-1:0]   out_keep,
    output logic                    out_last,
    output port_t                   out_ingress_port,
    output port_t                   out_egress_port
);

    logic                    dp_xfer;

    // bytes already seen in this packet before the current beat
    byte_len_t               byte_count;
    // set once the packet has been cut, until its last input beat
    logic                    cut_done;

    logic [KEEP_MAX-1:0]     keep_ext;
    byte_len_t               beat_bytes;
    logic [16:0]             total_bytes;
    logic                    trunc_on;
    logic                    cut_here;
    logic                    discard;
    byte_len_t               remain;
    logic [KEEP_MAX-1:0]     remain_mask;
    logic [DATA_BYTES-1:0]   trim_keep;

    assign dp_ready = !out_valid || out_ready;
    assign dp_xfer  = dp_valid && dp_ready;

    // ------------------------------------------------------------
    // cut point
    // ------------------------------------------------------------
    assign keep_ext    = KEEP_MAX'(dp_keep);
    assign beat_bytes  = keep_bytes(keep_ext);
    assign total_bytes = {1'b0, byte_count} + {1'b0, beat_bytes};

    assign trunc_on = (dp_trunc_length != BYTE_LEN_MAX);
    assign discard  = cut_done;

    // this beat reaches or crosses the length
    assign cut_here = trunc_on && !discard && (total_bytes >= {1'b0, dp_trunc_length});

    // at least one byte left here since the count was below the length
    assign remain      = dp_trunc_length - byte_count;
    assign remain_mask = keep_mask(remain);
    assign trim_keep   = dp_keep & remain_mask[DATA_BYTES-1:0];

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_count <= '0;
            cut_done   <= 1'b0;
        end else if (dp_xfer) begin
            if (dp_last) begin
                byte_count <= '0;
                cut_done   <= 1'b0;
            end else begin
                byte_count <= total_bytes[15:0];
                cut_done   <= discard || cut_here;
            end
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (dp_ready) begin
            out_valid <= dp_valid && !discard;
        end
    end

    always_ff @(posedge core_clk) begin
        if (dp_xfer && !discard) begin
            out_data         <= dp_data;
            out_keep         <= cut_here ? trim_keep : dp_keep;
            out_last         <= dp_last || cut_here;
            out_ingress_port <= dp_ingress_port;
            out_egress_port  <= dp_egress_port;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
common/pkt_proc_pkg.sv
hdl/meta_resolve.sv
pkt_drop/pkt_drop.sv
pkt_trunc/pkt_trunc.sv
hdl/pkt_proc_top.sv
test/pkt_proc_chk.sv
test/pkt_proc_tb.sv

// File: test/pkt_proc_chk.sv
`default_nettype none

module pkt_proc_chk
    import pkt_proc_pkg::*;
#(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic [DATA_BYTES*8-1:0] in_data,
    input  logic [DATA_BYTES-1:0]   in_keep,
    input  logic                    in_last,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic [DATA_BYTES*8-1:0] out_data,
    input  logic [DATA_BYTES-1:0]   out_keep,
    input  logic                    out_last,
    input  port_t                   out_ingress_port,
    input  port_t                   out_egress_port
);

    int assert_fails = 0;

    // a stalled output beat stays put until it transfers
    assert property (@(posedge core_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_ingress_port) && $stable(out_egress_port))
    else begin
        assert_fails++;
        $error("out stream changed while stalled");
    end

    // same rule on the input side
    assert property (@(posedge core_clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_keep)
            && $stable(in_last))
    else begin
        assert_fails++;
        $error("in stream changed while stalled");
    end

    assert property (@(posedge core_clk) disable iff (!rst_n)
        out_valid |-> out_keep != '0)
    else begin
        assert_fails++;
        $error("out beat with empty keep");
    end

endmodule

bind pkt_proc_top pkt_proc_chk #(
    .DATA_BYTES (DATA_BYTES)
) i_chk (
    .core_clk         (core_clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_data          (in_data),
    .in_keep          (in_keep),
    .in_last          (in_last),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_data         (out_data),
    .out_keep         (out_keep),
    .out_last         (out_last),
    .out_ingress_port (out_ingress_port),
    .out_egress_port  (out_egress_port)
);

`default_nettype wire

// File: test/pkt_proc_model.svh
`ifndef PKT_PROC_MODEL_SVH
`define PKT_PROC_MODEL_SVH

// expected output beats, one entry per beat in output order
logic [DATA_BYTES*8-1:0] exp_data [$];
logic [DATA_BYTES-1:0]   exp_keep [$];
logic                    exp_last [$];
port_t                   exp_ing  [$];
port_t                   exp_egr  [$];
int                      model_drops = 0;

// contiguous keep with the lowest n bytes set
function automatic logic [DATA_BYTES-1:0] keep_from_count(input int n);
    logic [DATA_BYTES-1:0] k;
    for (int i = 0; i < DATA_BYTES; i++) begin
        k[i] = (i < n);
    end
    return k;
endfunction

function automatic void push_expected(input logic [DATA_BYTES*8-1:0] data,
                                      input int nbytes, input logic last);
    exp_data.push_back(data);
    exp_keep.push_back(keep_from_count(nbytes));
    exp_last.push_back(last);
    exp_ing.push_back(pkt_ing);
    exp_egr.push_back(pkt_egr);
endfunction

// applies resolve, drop and cut rules to the packet held in pkt_*
task automatic model_packet();
    int  limit;
    int  total;
    bit  cut_on;
    bit  drop;
    if (cfg_trunc_override) begin
        limit = cfg_trunc_enable ? int'(cfg_trunc_length) : int'(BYTE_LEN_MAX);
    end else begin
        limit = pkt_ten ? int'(pkt_tlen) : int'(BYTE_LEN_MAX);
    end
    cut_on = (limit != int'(BYTE_LEN_MAX));
    drop   = (pkt_beats == 1 && pkt_nbytes[0] == 0) || (cfg_drop_loop && pkt_ing == pkt_egr);
    if (drop) begin
        model_drops++;
        return;
    end
    total = 0;
    for (int b = 0; b < pkt_beats; b++) begin
        if (cut_on && total + pkt_nbytes[b] >= limit) begin
            push_expected(pkt_data[b], limit - total, 1'b1);
            return;
        end
        push_expected(pkt_data[b], pkt_nbytes[b], b == pkt_beats - 1);
        total += pkt_nbytes[b];
    end
endtask

`endif

// File: test/pkt_proc_tb.sv
`default_nettype none

module pkt_proc_tb
    import pkt_proc_pkg::*;
;

    localparam int DATA_BYTES = 8;
    localparam int MAX_BEATS  = 6;

    logic                    core_clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_ready;
    logic [DATA_BYTES*8-1:0] in_data;
    logic [DATA_BYTES-1:0]   in_keep;
    logic                    in_last;
    port_t                   in_ingress_port;
    port_t                   in_egress_port;
    logic                    in_trunc_enable;
    byte_len_t               in_trunc_length;
    logic                    cfg_trunc_override;
    logic                    cfg_trunc_enable;
    byte_len_t               cfg_trunc_length;
    logic                    cfg_drop_loop;
    logic                    out_valid;
    logic                    out_ready;
    logic [DATA_BYTES*8-1:0] out_data;
    logic [DATA_BYTES-1:0]   out_keep;
    logic                    out_last;
    port_t                   out_ingress_port;
    port_t                   out_egress_port;
    logic [31:0]             drop_count;

    // packet currently being generated and sent
    logic [DATA_BYTES*8-1:0] pkt_data [MAX_BEATS];
    int                      pkt_nbytes [MAX_BEATS];
    int                      pkt_beats;
    port_t                   pkt_ing;
    port_t                   pkt_egr;
    logic                    pkt_ten;
    byte_len_t               pkt_tlen;

    int cycle_count  = 0;
    int accept_count = 0;
    int gen_beats    = 0;
    int checks       = 0;
    int errors       = 0;
    int test_num     = 1;
    int bp_pct       = 0;
    bit lat_check    = 0;
    int accept_cycles [$];

    `include "pkt_proc_model.svh"

    pkt_proc_top #(
        .DATA_BYTES (DATA_BYTES)
    ) i_dut (
        .core_clk (core_clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data),
        .in_keep (in_keep), .in_last (in_last),
        .in_ingress_port (in_ingress_port), .in_egress_port (in_egress_port),
        .in_trunc_enable (in_trunc_enable), .in_trunc_length (in_trunc_length),
        .cfg_trunc_override (cfg_trunc_override), .cfg_trunc_enable (cfg_trunc_enable),
        .cfg_trunc_length (cfg_trunc_length), .cfg_drop_loop (cfg_drop_loop),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .out_keep (out_keep), .out_last (out_last),
        .out_ingress_port (out_ingress_port), .out_egress_port (out_egress_port),
        .drop_count (drop_count)
    );

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    // random stall on the output side
    always @(negedge core_clk) begin
        out_ready = (bp_pct == 0) || ($urandom_range(99) >= bp_pct);
    end

    function automatic void compare_beat();
        checks++;
        if (exp_data.size() == 0) begin
            $display("ERROR at %0t: output beat arrived with nothing expected", $time);
            errors++;
            return;
        end
        if (out_data !== exp_data[0]) begin
            $display("MISMATCH at %0t: out_data expected %h got %h", $time, exp_data[0], out_data);
            errors++;
        end
        if (out_keep !== exp_keep[0]) begin
            $display("MISMATCH at %0t: out_keep expected %h got %h", $time, exp_keep[0], out_keep);
            errors++;
        end
        if (out_last !== exp_last[0]) begin
            $display("MISMATCH at %0t: out_last expected %b got %b", $time, exp_last[0], out_last);
            errors++;
        end
        if (out_ingress_port !== exp_ing[0] || out_egress_port !== exp_egr[0]) begin
            $display("MISMATCH at %0t: out_ingress_port/out_egress_port expected %h/%h got %h/%h",
                     $time, exp_ing[0], exp_egr[0], out_ingress_port, out_egress_port);
            errors++;
        end
        void'(exp_data.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
        void'(exp_ing.pop_front());
        void'(exp_egr.pop_front());
    endfunction

    // ------------------------------------------------------------
    // monitors and watchdog, all on the rising edge
    // ------------------------------------------------------------
    always @(posedge core_clk) begin
        cycle_count++;
        if (rst_n && in_valid && in_ready) begin
            accept_count++;
            if (lat_check) begin
                accept_cycles.push_back(cycle_count);
            end
        end
        if (rst_n && out_valid && out_ready) begin
            if (lat_check && accept_cycles.size() > 0) begin
                if (cycle_count - accept_cycles[0] != 3) begin
                    $display("ERROR at %0t: beat took %0d cycles instead of 3",
                             $time, cycle_count - accept_cycles[0]);
                    errors++;
                end
                void'(accept_cycles.pop_front());
            end
            compare_beat();
        end
        if (cycle_count >= 20 * gen_beats + 1000) begin
            $display("TIMEOUT: run stopped after %0d cycles without finishing", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic make_packet(input int zero_pct, input int loop_pct, input int trunc_pct);
        pkt_beats = $urandom_range(1, MAX_BEATS);
        for (int b = 0; b < pkt_beats; b++) begin
            pkt_nbytes[b] = DATA_BYTES;
            for (int i = 0; i < DATA_BYTES; i++) begin
                pkt_data[b][i*8 +: 8] = 8'($urandom_range(255));
            end
        end
        pkt_nbytes[pkt_beats-1] = $urandom_range(1, DATA_BYTES);
        if ($urandom_range(99) < zero_pct) begin
            pkt_beats     = 1;
            pkt_nbytes[0] = 0;
        end
        pkt_ing = port_t'($urandom_range(15));
        if ($urandom_range(99) < loop_pct) begin
            pkt_egr = pkt_ing;
        end else begin
            pkt_egr = pkt_ing ^ port_t'($urandom_range(1, 15));
        end
        pkt_ten   = ($urandom_range(99) < trunc_pct);
        pkt_tlen  = byte_len_t'($urandom_range(1, MAX_BEATS * DATA_BYTES + 8));
        gen_beats = gen_beats + pkt_beats;
    endtask

    // called at a falling edge, returns at a falling edge
    task automatic send_packet(input int gap_max);
        int target;
        for (int b = 0; b < pkt_beats; b++) begin
            target   = accept_count + 1;
            in_valid = 1'b1;
            in_data  = pkt_data[b];
            in_keep  = keep_from_count(pkt_nbytes[b]);
            in_last  = (b == pkt_beats - 1);
            // metadata only counts on the first beat, later beats carry noise
            in_ingress_port = (b == 0) ? pkt_ing : port_t'($urandom_range(15));
            in_egress_port  = (b == 0) ? pkt_egr : port_t'($urandom_range(15));
            in_trunc_enable = (b == 0) ? pkt_ten : 1'($urandom_range(1));
            in_trunc_length = (b == 0) ? pkt_tlen : byte_len_t'($urandom_range(1, 60));
            do @(negedge core_clk); while (accept_count < target);
        end
        in_valid = 1'b0;
        repeat ($urandom_range(gap_max)) @(negedge core_clk);
    endtask

    task automatic run_packets(input int n, input int zero_pct, input int loop_pct,
                               input int trunc_pct, input int gap_max);
        for (int p = 0; p < n; p++) begin
            make_packet(zero_pct, loop_pct, trunc_pct);
            model_packet();
            send_packet(gap_max);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() > 0 && waited < 300) begin
            @(negedge core_clk);
            waited++;
        end
        if (exp_data.size() > 0) begin
            $display("ERROR at %0t: %0d expected output beats never arrived",
                     $time, exp_data.size());
            errors++;
            exp_data.delete();
            exp_keep.delete();
            exp_last.delete();
            exp_ing.delete();
            exp_egr.delete();
        end
        // let dropped or cut beats clear the pipeline
        repeat (6) @(negedge core_clk);
    endtask

    task automatic set_cfg(input logic ovr, input logic en, input byte_len_t len,
                           input logic loop_drop);
        wait_drain();
        cfg_trunc_override = ovr;
        cfg_trunc_enable   = en;
        cfg_trunc_length   = len;
        cfg_drop_loop      = loop_drop;
        repeat (2) @(negedge core_clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        wait_drain();
        checks++;
        if (drop_count !== model_drops) begin
            $display("MISMATCH at %0t: drop_count expected %0d got %0d",
                     $time, model_drops, drop_count);
            errors++;
        end
        $display("test %0d %s finished with %0d errors", test_num, name, errors - errors_before);
        test_num++;
    endtask

    initial begin
        int start_errors;
        void'($urandom(32'h46c5));
        rst_n              = 1'b0;
        in_valid           = 1'b0;
        in_data            = '0;
        in_keep            = '0;
        in_last            = 1'b0;
        in_ingress_port    = '0;
        in_egress_port     = '0;
        in_trunc_enable    = 1'b0;
        in_trunc_length    = '0;
        cfg_trunc_override = 1'b0;
        cfg_trunc_enable   = 1'b0;
        cfg_trunc_length   = BYTE_LEN_MAX;
        cfg_drop_loop      = 1'b0;
        out_ready          = 1'b1;
        repeat (8) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;

        start_errors = errors;
        set_cfg(1'b0, 1'b0, BYTE_LEN_MAX, 1'b0);
        lat_check = 1'b1;
        run_packets(20, 0, 0, 0, 0);
        finish_test("pass_through", start_errors);
        lat_check = 1'b0;

        start_errors = errors;
        run_packets(10, 100, 0, 0, 1);
        finish_test("zero_length_drop", start_errors);

        start_errors = errors;
        set_cfg(1'b0, 1'b0, BYTE_LEN_MAX, 1'b1);
        run_packets(16, 0, 50, 0, 1);
        set_cfg(1'b0, 1'b0, BYTE_LEN_MAX, 1'b0);
        run_packets(16, 0, 50, 0, 1);
        finish_test("loop_drop", start_errors);

        start_errors = errors;
        run_packets(30, 0, 0, 60, 0);
        finish_test("metadata_trunc", start_errors);

        start_errors = errors;
        for (int s = 0; s < 3; s++) begin
            set_cfg(1'b1, 1'($urandom_range(1)), byte_len_t'($urandom_range(1, 56)), 1'b0);
            run_packets(10, 0, 0, 50, 0);
        end
        finish_test("cfg_override", start_errors);

        start_errors = errors;
        bp_pct = 40;
        for (int s = 0; s < 6; s++) begin
            set_cfg(1'($urandom_range(1)), 1'($urandom_range(1)),
                    byte_len_t'($urandom_range(1, 56)), 1'($urandom_range(1)));
            run_packets(15, 10, 20, 50, 2);
        end
        finish_test("backpressure_mix", start_errors);
        bp_pct = 0;

        errors = errors + i_dut.i_chk.assert_fails;
        $display("summary: %0d checks, %0d errors, %0d packets dropped",
                 checks, errors, model_drops);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
